/* n64ctrl_defines.svh */
// shared constants for the controller supervisor, include wherever bus timing or limits are needed
`ifndef N64CTRL_DEFINES_SVH
`define N64CTRL_DEFINES_SVH

//////////////////////////////
// controller bus timing
//////////////////////////////

// phase counter saturates here
// bus must idle this long before a frame, a flat phase this long aborts one
`define N64_IDLE_CNT 6'd63

`define N64_CMD_POLL 8'h01       // console poll request, sent lsb first

//////////////////////////////
// in-game reset
//////////////////////////////

// A + B + Z + Start + R, bit order as in ctrl_fields_t.buttons
`define IGR_RESET_COMBO 16'h080F

`define RST_HOLD_CYCLES 16       // console reset drive length in CLK_16k cycles

//////////////////////////////
// host path
//////////////////////////////

`define REPORT_DEPTH 4           // queue entries, power of two
`define HOST_CREDITS 2           // host side buffer slots

`endif

/* n64ctrl_pkg.sv */
// types shared by the supervisor blocks, imported by every module that passes reports or config
`default_nettype none

package n64ctrl_pkg;

  // controller response, first bit on the wire ends up in bit 0
  //  [7:0]   A, B, Z, Start, Du, Dd, Dl, Dr
  //  [15:8]  joystick reset, (0), L, R, Cu, Cd, Cl, Cr
  typedef struct packed {
    logic [7:0]  y_axis;
    logic [7:0]  x_axis;
    logic [15:0] buttons;
  } ctrl_fields_t;

  typedef union packed {
    logic [31:0]  raw;     // as sampled
    ctrl_fields_t fields;  // decoded view
  } ctrl_word_u;

  // misc settings on top, video settings below
  typedef struct packed {
    logic [3:0]  rsvd_hi;
    logic        sl_in_osd;  // scanlines stay on behind the OSD
    logic        show_logo;
    logic        show_osd;
    logic        mute_osd;
    logic [4:0]  rsvd_mid;
    logic        use_igr;    // in-game reset enable
    logic [1:0]  igr_opt;    // host side only
    logic [15:0] video;      // gamma, deblur, 15bit mode
  } sys_cfg0_t;

  typedef struct packed {
    logic [15:0] sl_240p;    // scanline setup for 240p
    logic [15:0] sl_480i;    // scanline setup for 480i
  } sys_cfg1_t;

  // video word then scanline words, bit 46 carries the OSD scanline gate
  typedef struct packed {
    logic [15:0] video;
    logic [31:0] scanline;
  } out_cfg_t;

  typedef struct packed {
    logic logo;
    logic osd;
  } osd_info_t;

  typedef struct packed {
    logic       valid;  // one cycle pulse per response
    ctrl_word_u word;
  } ctrl_report_t;

endpackage

`default_nettype wire

/* ctrl_sniffer.sv */
// listens on the single-wire controller bus and reports each response that follows a poll
`timescale 1ns/100ps
`default_nettype none
`include "n64ctrl_defines.svh"

module ctrl_sniffer import n64ctrl_pkg::*; (
  input  logic         CLK_16k,
  input  logic         nVRST,
  input  logic         ctrl,
  output ctrl_report_t rpt
);

  localparam logic [1:0] ST_WAIT = 2'd0;  // wait for console request
  localparam logic [1:0] ST_CMD  = 2'd1;  // console command byte
  localparam logic [1:0] ST_RESP = 2'd2;  // controller answer

  logic [1:0]  state;
  logic [2:0]  ctrl_hist;   // sample history, [0] newest
  logic [5:0]  phase_cnt;   // length of the current flat phase
  logic [5:0]  low_cnt;     // length of the last low phase
  logic [5:0]  bit_cnt;
  logic [31:0] shift_q;     // bits enter at the top, lsb first
  logic        rpt_valid;
  logic        ctrl_fall;
  logic        ctrl_rise;
  logic        cnt_sat;
  logic        rx_bit;

  assign ctrl_fall = ctrl_hist[2] & ~ctrl_hist[1];
  assign ctrl_rise = ~ctrl_hist[2] & ctrl_hist[1];
  assign cnt_sat   = (phase_cnt == `N64_IDLE_CNT);
  assign rx_bit    = (low_cnt < phase_cnt);  // short low, long high means one

  assign rpt = {rpt_valid, shift_q};

  //////////////////////////////
  // edge and phase tracking
  //////////////////////////////

  always_ff @(posedge CLK_16k) begin
    if (!nVRST) begin
      ctrl_hist <= 3'b111;  // idle bus is high
      phase_cnt <= '0;
      low_cnt   <= '0;
    end else begin
      ctrl_hist <= {ctrl_hist[1:0], ctrl};
      if (ctrl_fall | ctrl_rise)
        phase_cnt <= '0;
      else if (!cnt_sat)
        phase_cnt <= phase_cnt + 1'b1;  // saturating
      if (ctrl_rise)
        low_cnt <= phase_cnt;           // low phase just ended
    end
  end

  //////////////////////////////
  // frame FSM
  //////////////////////////////

  always_ff @(posedge CLK_16k) begin
    if (!nVRST) begin
      state     <= ST_WAIT;
      bit_cnt   <= '0;
      shift_q   <= '0;
      rpt_valid <= 1'b0;
    end else begin
      rpt_valid <= 1'b0;
      case (state)
        ST_WAIT: begin
          if (cnt_sat & ctrl_fall) begin  // frame start only after a long idle
            state   <= ST_CMD;
            bit_cnt <= '0;
          end
        end
        ST_CMD: begin
          if (cnt_sat) begin
            state <= ST_WAIT;             // bus stuck, give up
          end else if (ctrl_fall) begin
            if (bit_cnt != 6'd8) begin
              shift_q <= {rx_bit, shift_q[31:1]};
              bit_cnt <= bit_cnt + 1'b1;
            end else if (shift_q[31:24] == `N64_CMD_POLL) begin
              state   <= ST_RESP;         // this fall starts response bit 0
              bit_cnt <= '0;
            end else begin
              state <= ST_WAIT;           // not a poll
            end
          end
        end
        ST_RESP: begin
          if (cnt_sat) begin
            state <= ST_WAIT;
          end else if (ctrl_fall && bit_cnt != 6'd32) begin
            shift_q <= {rx_bit, shift_q[31:1]};  // stop bit fall closes bit 31
            bit_cnt <= bit_cnt + 1'b1;
          end else if (ctrl_rise && bit_cnt == 6'd32) begin
            rpt_valid <= 1'b1;            // stop bit released
            state     <= ST_WAIT;
          end
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* report_queue.sv */
// holds controller reports and hands them to the host processor against returned credits
`timescale 1ns/100ps
`default_nettype none
`include "n64ctrl_defines.svh"

module report_queue import n64ctrl_pkg::*; (
  input  logic         CLK_16k,
  input  logic         nVRST,
  input  ctrl_report_t rpt,
  input  logic         credit_ret,
  output ctrl_word_u   host_rpt,
  output logic         host_valid,
  output logic         overflow
);

  localparam int unsigned AW = $clog2(`REPORT_DEPTH);
  localparam int unsigned FW = $clog2(`REPORT_DEPTH + 1);
  localparam int unsigned CW = $clog2(`HOST_CREDITS + 1);
  localparam logic [FW-1:0] FILL_MAX = FW'(`REPORT_DEPTH);
  localparam logic [CW-1:0] CRED_MAX = CW'(`HOST_CREDITS);

  ctrl_word_u    mem [`REPORT_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;   // pointers wrap, depth is a power of two
  logic [FW-1:0] fill;
  logic [CW-1:0] credits;  // free host slots
  logic          full;
  logic          push;

  assign full       = (fill == FILL_MAX);
  assign host_valid = (fill != '0) && (credits != '0);  // one word per credit
  assign push       = rpt.valid && (!full || host_valid); // a pop frees a slot
  assign host_rpt   = mem[rd_ptr];

  always_ff @(posedge CLK_16k) begin
    if (push)
      mem[wr_ptr] <= rpt.word;
  end

  always_ff @(posedge CLK_16k) begin
    if (!nVRST) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      credits  <= CRED_MAX;
      overflow <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (host_valid)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, host_valid})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase
      case ({host_valid, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   if (credits != CRED_MAX) credits <= credits + 1'b1;  // ignore extra returns
        default: ;
      endcase
      if (rpt.valid && !push)
        overflow <= 1'b1;  // sticky until reset
    end
  end

endmodule

`default_nettype wire

/* sys_reset_ctrl.sv */
// turns the in-game reset combo into a timed console reset and detects fallback mode at power-on
`timescale 1ns/100ps
`default_nettype none
`include "n64ctrl_defines.svh"

module sys_reset_ctrl import n64ctrl_pkg::*; (
  input  logic         CLK_16k,
  input  logic         nVRST,
  input  ctrl_report_t rpt,
  input  logic         use_igr,
  input  logic         n_rst_btn,
  output logic         rst_drive,
  output logic         fallback_mode
);

  localparam int unsigned HW = $clog2(`RST_HOLD_CYCLES + 1);
  localparam logic [HW-1:0] HOLD_LOAD = HW'(`RST_HOLD_CYCLES);

  logic [HW-1:0] hold_cnt;     // remaining drive cycles
  logic          first_cycle;  // high in the first cycle after reset
  logic          combo_hit;

  assign combo_hit = rpt.valid && use_igr &&
                     (rpt.word.fields.buttons == `IGR_RESET_COMBO);
  assign rst_drive = (hold_cnt != '0);

  always_ff @(posedge CLK_16k) begin
    if (!nVRST) begin
      hold_cnt      <= '0;
      first_cycle   <= 1'b1;
      fallback_mode <= 1'b0;
    end else begin
      if (combo_hit)
        hold_cnt <= HOLD_LOAD;           // also restarts a running drive
      else if (rst_drive)
        hold_cnt <= hold_cnt - 1'b1;
      first_cycle <= 1'b0;
      if (first_cycle)
        fallback_mode <= ~n_rst_btn;     // button held out of reset
      else
        fallback_mode <= fallback_mode & ~n_rst_btn;  // lost once released
    end
  end

endmodule

`default_nettype wire

/* cfg_latch.sv */
// takes host config words at each falling vsync and derives the output config and OSD bits
`timescale 1ns/100ps
`default_nettype none

module cfg_latch import n64ctrl_pkg::*; (
  input  logic      CLK_16k,
  input  logic      nVRST,
  input  logic      vd_vsync,
  input  sys_cfg0_t sys_cfg0,
  input  sys_cfg1_t sys_cfg1,
  output out_cfg_t  out_cfg,
  output osd_info_t osd_info,
  output logic      use_igr
);

  logic vsync_q;
  logic vsync_fall;  // registered edge pulse
  logic osd_on;
  logic osd_sl;

  assign osd_on = sys_cfg0.show_osd & ~sys_cfg0.mute_osd;
  // OSD scanlines only matter while the OSD is actually visible
  assign osd_sl = sys_cfg0.sl_in_osd | ~sys_cfg0.show_osd | sys_cfg0.mute_osd;

  always_ff @(posedge CLK_16k) begin
    if (!nVRST) begin
      vsync_q    <= 1'b0;
      vsync_fall <= 1'b0;
      out_cfg    <= '0;
      osd_info   <= '0;
      use_igr    <= 1'b0;
    end else begin
      vsync_q    <= vd_vsync;
      vsync_fall <= vsync_q & ~vd_vsync;
      if (vsync_fall) begin
        out_cfg       <= {sys_cfg0.video[15], osd_sl, sys_cfg0.video[13:0], sys_cfg1};
        osd_info.osd  <= osd_on;
        osd_info.logo <= osd_on & sys_cfg0.show_logo;  // logo only inside OSD
        use_igr       <= sys_cfg0.use_igr;
      end
    end
  end

endmodule

`default_nettype wire

/* n64ctrl_top.sv */
// top of the controller supervisor, connects sniffer, host queue, reset control and config latch
`timescale 1ns/100ps
`default_nettype none

module n64ctrl_top import n64ctrl_pkg::*; (
  input  logic       CLK_16k,
  input  logic       nVRST,
  input  logic       ctrl,
  input  logic       n_rst_btn,
  input  logic       vd_vsync,
  input  sys_cfg0_t  sys_cfg0,
  input  sys_cfg1_t  sys_cfg1,
  input  logic       credit_ret,
  output ctrl_word_u host_rpt,
  output logic       host_valid,
  output logic       overflow,
  output logic       rst_drive,
  output logic       fallback_mode,
  output out_cfg_t   out_cfg,
  output osd_info_t  osd_info
);

  ctrl_report_t rpt;      // to queue and reset control alike
  logic         use_igr;  // from the vsync latch

  ctrl_sniffer u_sniffer (
    .CLK_16k (CLK_16k),
    .nVRST   (nVRST),
    .ctrl    (ctrl),
    .rpt     (rpt)
  );

  report_queue u_queue (
    .CLK_16k    (CLK_16k),
    .nVRST      (nVRST),
    .rpt        (rpt),
    .credit_ret (credit_ret),
    .host_rpt   (host_rpt),
    .host_valid (host_valid),
    .overflow   (overflow)
  );

  sys_reset_ctrl u_rst (
    .CLK_16k       (CLK_16k),
    .nVRST         (nVRST),
    .rpt           (rpt),
    .use_igr       (use_igr),
    .n_rst_btn     (n_rst_btn),
    .rst_drive     (rst_drive),
    .fallback_mode (fallback_mode)
  );

  cfg_latch u_cfg (
    .CLK_16k  (CLK_16k),
    .nVRST    (nVRST),
    .vd_vsync (vd_vsync),
    .sys_cfg0 (sys_cfg0),
    .sys_cfg1 (sys_cfg1),
    .out_cfg  (out_cfg),
    .osd_info (osd_info),
    .use_igr  (use_igr)
  );

endmodule

`default_nettype wire

/* n64ctrl_assertions.sv */
// concurrent checks on the host credit rule and the reset drive length, bound into the design
`timescale 1ns/100ps
`default_nettype none
`include "n64ctrl_defines.svh"

module n64ctrl_assertions #(
  parameter int unsigned CW = $clog2(`HOST_CREDITS + 1)
) (
  input logic          CLK_16k,
  input logic          nVRST,
  input logic          host_valid,
  input logic          credit_ret,
  input logic [CW-1:0] credits,    // free host slots inside the queue
  input logic          rst_drive
);

  int unsigned drive_len;    // cycles rst_drive has been high so far
  int          outstanding;  // words at the host not yet credited back
  int          fails = 0;    // assertion failures so far

  always_ff @(posedge CLK_16k) begin
    if (!nVRST)
      drive_len <= 0;
    else if (rst_drive)
      drive_len <= drive_len + 1;
    else
      drive_len <= 0;
  end

  // host side view of the slots, taken from the bus only
  always_ff @(posedge CLK_16k) begin
    if (!nVRST)
      outstanding <= 0;
    else if (host_valid && !credit_ret)
      outstanding <= outstanding + 1;
    else if (credit_ret && !host_valid && outstanding != 0)
      outstanding <= outstanding - 1;  // extra returns change nothing
  end

  // a word may only leave while the host has a free slot
  credit_used: assert property (@(posedge CLK_16k) disable iff (!nVRST)
    host_valid |-> (outstanding < `HOST_CREDITS))
    else begin
      $error("host word sent without credit");
      fails++;
    end

  // queue credits plus words at the host never exceed the host slots
  credit_limit: assert property (@(posedge CLK_16k) disable iff (!nVRST)
    (int'(credits) + outstanding) <= `HOST_CREDITS)
    else begin
      $error("credit count above host slots");
      fails++;
    end

  // pulse length seen at the falling edge of the drive
  drive_length: assert property (@(posedge CLK_16k) disable iff (!nVRST)
    $fell(rst_drive) |-> (drive_len == `RST_HOLD_CYCLES))
    else begin
      $error("console reset drive length wrong");
      fails++;
    end

endmodule

bind report_queue n64ctrl_assertions u_queue_chk (
  .CLK_16k, .nVRST, .host_valid, .credit_ret, .credits, .rst_drive (1'b0)
);

bind sys_reset_ctrl n64ctrl_assertions u_rst_chk (
  .CLK_16k, .nVRST, .host_valid (1'b0), .credit_ret (1'b0), .credits ('0), .rst_drive
);

`default_nettype wire

/* tb_n64ctrl.sv */
// directed testbench for the controller supervisor, the simulation top
`timescale 1ns/100ps
`default_nettype none
`include "n64ctrl_defines.svh"

module tb_n64ctrl import n64ctrl_pkg::*; ();

  logic       CLK_16k;
  logic       nVRST;
  logic       ctrl;
  logic       n_rst_btn;
  logic       vd_vsync;
  sys_cfg0_t  sys_cfg0;
  sys_cfg1_t  sys_cfg1;
  logic       credit_ret;
  ctrl_word_u host_rpt;
  logic       host_valid;
  logic       overflow;
  logic       rst_drive;
  logic       fallback_mode;
  out_cfg_t   out_cfg;
  osd_info_t  osd_info;

  int         seed = 53333;
  int         errors = 0;
  int         checks = 0;
  ctrl_word_u sent_q[$];  // answered polls, in bus order
  ctrl_word_u got_q[$];   // words taken by the host

  n64ctrl_top u_dut (.*);

  initial begin
    CLK_16k = 1'b0;
    forever #20 CLK_16k = ~CLK_16k;  // 40 ns period
  end

  // host model, one word per host_valid cycle
  always @(negedge CLK_16k) begin
    if (host_valid)
      got_q.push_back(host_rpt);
  end

  //////////////////////////////
  // checks and expected values
  //////////////////////////////

  task automatic check_word(input string name, input ctrl_word_u got, input ctrl_word_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_cfg(input string name, input out_cfg_t got, input out_cfg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_osd(input string name, input osd_info_t got, input osd_info_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // word count and order against the answered polls
  task automatic check_delivered(input int n);
    int k;
    checks++;
    if (got_q.size() != n) begin
      errors++;
      $display("error host word count: got %h expected %h", got_q.size(), n);
    end
    for (k = 0; k < n && k < got_q.size(); k++)
      check_word("host_rpt", got_q[k], sent_q[k]);
  endtask

  function automatic out_cfg_t expect_cfg(input sys_cfg0_t c0, input sys_cfg1_t c1);
    out_cfg_t r;
    r.video     = c0.video;
    r.video[14] = c0.sl_in_osd | ~c0.show_osd | c0.mute_osd;  // bit 46, OSD scanline gate
    r.scanline  = c1;
    return r;
  endfunction

  function automatic osd_info_t expect_osd(input sys_cfg0_t c0);
    osd_info_t r;
    r.osd  = c0.show_osd & ~c0.mute_osd;
    r.logo = r.osd & c0.show_logo;
    return r;
  endfunction

  //////////////////////////////
  // bus driver and host side
  //////////////////////////////

  task automatic tick(input int n);
    repeat (n) @(posedge CLK_16k);
  endtask

  task automatic do_reset(input logic btn);
    @(posedge CLK_16k);
    nVRST      <= 1'b0;
    n_rst_btn  <= btn;
    ctrl       <= 1'b1;
    credit_ret <= 1'b0;
    vd_vsync   <= 1'b1;
    tick(5);
    nVRST <= 1'b1;
    got_q.delete();
    sent_q.delete();
  endtask

  task automatic drive_level(input logic lvl, input int n);
    repeat (n) begin
      @(posedge CLK_16k);
      ctrl <= lvl;
    end
  endtask

  // zero is long low, one is short low
  task automatic send_bit(input logic b);
    drive_level(1'b0, b ? 1 : 3);
    drive_level(1'b1, b ? 3 : 1);
  endtask

  task automatic send_frame(input logic [7:0] cmd, input ctrl_word_u w);
    int i;
    drive_level(1'b1, 70);  // idle past the saturating count
    for (i = 0; i < 8; i++)
      send_bit(cmd[i]);
    send_bit(1'b1);         // console stop bit
    for (i = 0; i < 32; i++)
      send_bit(w.raw[i]);
    drive_level(1'b0, 1);   // controller stop bit
    drive_level(1'b1, 1);
  endtask

  task automatic send_random(input logic [7:0] cmd);
    ctrl_word_u w;
    w.raw = $random(seed);
    if (cmd == `N64_CMD_POLL)
      sent_q.push_back(w);  // only polls get a report
    send_frame(cmd, w);
  endtask

  task automatic release_words(input int n);
    int k;
    int t;
    int base;
    for (k = 0; k < n; k++) begin
      base = got_q.size();
      @(posedge CLK_16k);
      credit_ret <= 1'b1;
      @(posedge CLK_16k);
      credit_ret <= 1'b0;
      t = 0;
      while (got_q.size() == base && t < 20) begin
        @(negedge CLK_16k);
        t++;
      end
      if (got_q.size() == base) begin
        errors++;
        $display("timeout: no host word after a credit return");
      end
    end
  endtask

  task automatic latch_cfg(input logic igr);
    sys_cfg0_t c0;
    c0         = $random(seed);
    c0.use_igr = igr;
    @(posedge CLK_16k);
    sys_cfg0 <= c0;
    vd_vsync <= 1'b0;
    tick(3);
    vd_vsync <= 1'b1;
    tick(2);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic poll_delivery();
    int t;
    do_reset(1'b1);
    send_random(`N64_CMD_POLL);
    t = 0;
    while (!u_dut.rpt.valid && t < 20) begin
      @(negedge CLK_16k);
      t++;
    end
    if (t == 20) begin
      errors++;
      $display("timeout: sniffer reported no response");
    end
    @(negedge CLK_16k);  // one cycle after the report
    check_bit("host_valid", host_valid, 1'b1);
    check_word("host_rpt", host_rpt, sent_q[0]);
    send_random(8'h00);  // status request, no report
    tick(80);
    check_delivered(1);
  endtask

  task automatic credit_backpressure();
    int k;
    do_reset(1'b1);
    for (k = 0; k < 5; k++)
      send_random(`N64_CMD_POLL);  // two use the credits, three wait
    tick(6);
    @(negedge CLK_16k);
    check_bit("host_valid", host_valid, 1'b0);
    check_delivered(2);
    release_words(3);
    tick(20);
    check_delivered(5);
  endtask

  task automatic queue_overflow();
    int k;
    do_reset(1'b1);
    for (k = 0; k < 7; k++) begin
      send_random(`N64_CMD_POLL);
      tick(6);
      @(negedge CLK_16k);
      check_bit("overflow", overflow, k == 6);  // only the seventh is dropped
    end
    check_delivered(2);
    release_words(4);
    tick(20);
    check_delivered(6);
  endtask

  task automatic igr_reset();
    ctrl_word_u w;
    int t;
    int len;
    logic seen;
    do_reset(1'b1);
    latch_cfg(1'b1);
    w.raw            = $random(seed);
    w.fields.buttons = `IGR_RESET_COMBO;
    send_frame(`N64_CMD_POLL, w);
    t = 0;
    while (!rst_drive && t < 20) begin
      @(negedge CLK_16k);
      t++;
    end
    len = 0;
    while (rst_drive && len < 40) begin
      @(negedge CLK_16k);
      len++;
    end
    checks++;
    if (len != `RST_HOLD_CYCLES) begin
      errors++;
      $display("error rst_drive length: got %h expected %h", len, `RST_HOLD_CYCLES);
    end
    latch_cfg(1'b0);
    send_frame(`N64_CMD_POLL, w);
    seen = 1'b0;
    repeat (40) begin
      @(negedge CLK_16k);
      seen = seen | rst_drive;
    end
    check_bit("rst_drive", seen, 1'b0);
  endtask

  task automatic fallback_detect();
    do_reset(1'b0);  // button held through reset
    tick(3);
    @(negedge CLK_16k);
    check_bit("fallback_mode", fallback_mode, 1'b1);
    tick(1);
    n_rst_btn <= 1'b1;
    tick(2);
    @(negedge CLK_16k);
    check_bit("fallback_mode", fallback_mode, 1'b0);
    do_reset(1'b1);
    tick(3);
    n_rst_btn <= 1'b0;  // pressed after power-on
    tick(3);
    @(negedge CLK_16k);
    check_bit("fallback_mode", fallback_mode, 1'b0);
  endtask

  task automatic vsync_config();
    sys_cfg0_t c0;
    sys_cfg1_t c1;
    out_cfg_t  prev_cfg;
    osd_info_t prev_osd;
    int        k;
    do_reset(1'b1);
    prev_cfg = '0;
    prev_osd = '0;
    for (k = 0; k < 4; k++) begin
      c0 = $random(seed);
      c1 = $random(seed);
      @(posedge CLK_16k);
      sys_cfg0 <= c0;
      sys_cfg1 <= c1;
      tick(3);
      vd_vsync <= 1'b0;  // falling vsync
      tick(1);
      @(negedge CLK_16k);
      check_cfg("out_cfg", out_cfg, prev_cfg);  // sync still in its register
      check_osd("osd_info", osd_info, prev_osd);
      tick(1);
      @(negedge CLK_16k);
      prev_cfg = expect_cfg(c0, c1);
      prev_osd = expect_osd(c0);
      check_cfg("out_cfg", out_cfg, prev_cfg);
      check_osd("osd_info", osd_info, prev_osd);
      tick(1);
      vd_vsync <= 1'b1;
    end
  endtask

  initial begin
    nVRST      = 1'b0;
    ctrl       = 1'b1;
    n_rst_btn  = 1'b1;
    vd_vsync   = 1'b1;
    credit_ret = 1'b0;
    sys_cfg0   = '0;
    sys_cfg1   = '0;
    poll_delivery();
    credit_backpressure();
    queue_overflow();
    igr_reset();
    fallback_detect();
    vsync_config();
    errors += u_dut.u_queue.u_queue_chk.fails + u_dut.u_rst.u_rst_chk.fails;
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
n64ctrl_pkg.sv
ctrl_sniffer.sv
report_queue.sv
sys_reset_ctrl.sv
cfg_latch.sv
n64ctrl_top.sv
n64ctrl_assertions.sv
tb_n64ctrl.sv

/* run.sh */
#!/bin/sh
# builds the supervisor testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_n64ctrl -f src.f -o sim_n64ctrl
./obj_dir/sim_n64ctrl > sim.log 2>&1 || true
cat sim.log
if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
